// ==== Makefile ====
# Verilator build and run of the MCU bridge testbench

SIM := obj_dir/cop_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cop_tb -f project.f -o cop_sim

# Pass only when the simulator printed the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+verification
verilog/cop_pkg.sv
verilog/cop_cen_gen.sv
verilog/cop_mcu_mailbox.sv
verilog/cop_mcu_irq.sv
verilog/cop_status_dump.sv
verilog/cop_mcu_bridge.sv
verification/cop_tb.sv

// ==== verification/cop_tb_checks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge testbench compare tasks
// Typed checks, per-test report
// lines and the run counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef COP_TB_CHECKS_SVH
`define COP_TB_CHECKS_SVH

    int unsigned check_total   = 0;
    int unsigned err_count     = 0;
    int unsigned tests_run     = 0;
    int unsigned tests_failed  = 0;
    int unsigned test_err_base = 0;
    string       test_name     = "";

    task automatic check_byte(input string what, input port_byte_t got, input port_byte_t exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input host_word_t got, input host_word_t exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = err_count;
        tests_run++;
    endtask

    // One report line as each test finishes
    task automatic end_test();
        if (err_count == test_err_base) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, test_name,
                     err_count - test_err_base);
        end
    endtask

`endif

// ==== verification/cop_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU bridge testbench
// Drives the bridge pins, runs a
// cycle model beside the DUT and
// compares every output each cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_tb;

    import cop_pkg::*;

    localparam int unsigned SETTLE_LIMIT = 4;
    localparam int unsigned IRQ_LIMIT    = 8;
    localparam int unsigned RUN_SEED     = 32'hc8806120;

    logic       clk;
    logic       rst24;
    host_word_t host_din;
    mcu_sel_t   mcu_sel;
    port_byte_t p0_out;
    port_byte_t p1_out;
    port_byte_t p2_out;
    port_byte_t p3_out;
    st_addr_t   st_addr;
    logic       cen_mcu;
    logic       cen_opl;
    logic       cen_opn;
    port_byte_t p0_in;
    port_byte_t p3_in;
    logic       int1n;
    host_word_t host_dout;
    port_byte_t st_dout;
    logic [1:0] snd_flag;
    logic [1:0] b1_flag;
    logic       b0_flag;
    logic [1:0] mix_flag;
    logic [2:0] crback;

    // Model state, stepped on each rising edge
    int unsigned m_cnt;
    port_byte_t  m_p0_in;
    host_word_t  m_host_dout;
    logic        m_int1n;
    logic        m_sel_l;
    port_byte_t  m_st_dout;
    int unsigned check_cnt;

    `include "cop_tb_checks.svh"

    cop_mcu_bridge u_dut (.*);

    always #50 clk = ~clk;

    function automatic logic ref_cen(input int unsigned cnt, input int unsigned div);
        return (cnt % div) == (div - 1);
    endfunction

    // Low byte wins when both read strobes are down
    function automatic port_byte_t ref_p0_in(input port_byte_t cur, input host_word_t din,
                                             input port_byte_t p2);
        if (!p2[P2_RD_LO]) begin
            return din[7:0];
        end
        if (!p2[P2_RD_HI]) begin
            return din[15:8];
        end
        return cur;
    endfunction

    // Select lines 5:3 replace the top three bits of port 3
    function automatic port_byte_t ref_p3_in(input mcu_sel_t sel, input port_byte_t p3);
        port_byte_t v;
        v      = p3;
        v[7:5] = sel[5:3];
        return v;
    endfunction

    function automatic host_word_t ref_host_dout(input host_word_t cur, input port_byte_t p0,
                                                 input port_byte_t p2);
        host_word_t w;
        w = cur;
        if (!p2[P2_WR_HI]) begin
            w[15:8] = p0;
        end
        if (!p2[P2_WR_LO]) begin
            w[7:0] = p0;
        end
        return w;
    endfunction

    function automatic logic ref_int1n(input logic cur, input logic sel, input logic sel_l,
                                       input port_byte_t p2);
        if (!p2[P2_IRQ_CLR]) begin
            return 1'b1;
        end
        return (sel && !sel_l) ? 1'b0 : cur;
    endfunction

    function automatic port_byte_t ref_st_dout(input st_addr_t addr, input host_word_t hd,
                                               input port_byte_t p1, input port_byte_t p3,
                                               input logic irq_n);
        case (addr[7:6])
            ST_PAGE_LO:   return hd[7:0];
            ST_PAGE_HI:   return hd[15:8];
            ST_PAGE_BANK: return {1'b0, p1[6:0]};
            default:      return {irq_n, 4'b0000, p3[2:0]};
        endcase
    endfunction

    // snd, b1, b0, mix packed top to bottom
    function automatic port_byte_t ref_flags(input port_byte_t p1);
        return {1'b0, p1[6:5], p1[4:3], p1[2], p1[1:0]};
    endfunction

    function automatic port_byte_t strobe_low(input int unsigned pos);
        port_byte_t m;
        m      = 8'hff;
        m[pos] = 1'b0;
        return m;
    endfunction

    // Model steps on the edge, DUT is sampled 10 ns later
    always @(posedge clk) begin
        if (rst24) begin
            m_cnt       = 0;
            m_p0_in     = '0;
            m_host_dout = '0;
            m_int1n     = 1'b1;
            m_sel_l     = 1'b0;
            m_st_dout   = '0;
        end else begin
            m_st_dout   = ref_st_dout(st_addr, m_host_dout, p1_out, p3_out, m_int1n);
            m_p0_in     = ref_p0_in(m_p0_in, host_din, p2_out);
            m_host_dout = ref_host_dout(m_host_dout, p0_out, p2_out);
            m_int1n     = ref_int1n(m_int1n, mcu_sel[0], m_sel_l, p2_out);
            m_sel_l     = mcu_sel[0];
            m_cnt       = (m_cnt + 1) % CEN_MODULUS;
            #10;
            check_bit("cen_mcu", cen_mcu, ref_cen(m_cnt, MCU_DIV));
            check_bit("cen_opl", cen_opl, ref_cen(m_cnt, OPL_DIV));
            check_bit("cen_opn", cen_opn, ref_cen(m_cnt, OPN_DIV));
            check_byte("p0_in", p0_in, m_p0_in);
            check_word("host_dout", host_dout, m_host_dout);
            check_bit("int1n", int1n, m_int1n);
            check_byte("st_dout", st_dout, m_st_dout);
            check_byte("p3_in", p3_in, ref_p3_in(mcu_sel, p3_out));
            check_byte("bank flags", {1'b0, snd_flag, b1_flag, b0_flag, mix_flag},
                       ref_flags(p1_out));
            check_byte("crback", {5'b00000, crback}, {5'b00000, p3_out[2:0]});
            check_cnt++;
        end
    end

    task automatic end_run(input logic timed_out);
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_total, err_count);
        if (timed_out || err_count != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    endtask

    // Returns on the falling edge after the model has compared
    task automatic settle();
        int unsigned start;
        int unsigned n;
        start = check_cnt;
        n     = 0;
        while (check_cnt == start) begin
            if (n == SETTLE_LIMIT) begin
                $display("Timeout: no output compare after the last stimulus");
                end_run(1'b1);
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_int1n(input logic level);
        int unsigned n;
        n = 0;
        while (int1n !== level) begin
            if (n == IRQ_LIMIT) begin
                $display("Timeout: int1n never reached %b", level);
                end_run(1'b1);
            end
            settle();
            n++;
        end
    endtask

    initial begin
        int unsigned i;
        int unsigned pg;
        void'($urandom(RUN_SEED));
        clk       = 1'b0;
        rst24     = 1'b1;
        host_din  = '0;
        mcu_sel   = '0;
        p0_out    = '0;
        p1_out    = '0;
        p2_out    = 8'hff;
        p3_out    = '0;
        st_addr   = '0;
        check_cnt = 0;

        begin_test("reset and clock enables");
        repeat (2) @(negedge clk);
        check_bit("int1n in reset", int1n, 1'b1);
        check_byte("p0_in in reset", p0_in, 8'h00);
        check_word("host_dout in reset", host_dout, 16'h0000);
        check_byte("st_dout in reset", st_dout, 8'h00);
        rst24 = 1'b0;
        for (i = 0; i < 96; i++) begin
            settle();
        end
        end_test();

        begin_test("mcu reads");
        for (i = 0; i < 8; i++) begin
            host_din = host_word_t'($urandom);
            mcu_sel  = mcu_sel_t'($urandom);
            p3_out   = port_byte_t'($urandom);
            p2_out   = strobe_low(P2_RD_HI);
            settle();
            p2_out   = strobe_low(P2_RD_LO);
            settle();
            p2_out   = strobe_low(P2_RD_HI) & strobe_low(P2_RD_LO);
            settle();
        end
        end_test();

        begin_test("mcu writes");
        for (i = 0; i < 8; i++) begin
            p0_out = port_byte_t'($urandom);
            p2_out = strobe_low(P2_WR_HI);
            settle();
            p0_out = port_byte_t'($urandom);
            p2_out = strobe_low(P2_WR_LO);
            settle();
            p0_out = port_byte_t'($urandom);
            p2_out = strobe_low(P2_WR_HI) & strobe_low(P2_WR_LO);
            settle();
        end
        end_test();

        begin_test("interrupt");
        p2_out  = 8'hff;
        mcu_sel = '0;
        settle();
        settle();
        mcu_sel[0] = 1'b1;
        wait_int1n(1'b0);
        // Select held high, request stays put
        for (i = 0; i < 4; i++) begin
            settle();
        end
        p2_out = strobe_low(P2_IRQ_CLR);
        settle();
        p2_out = 8'hff;
        wait_int1n(1'b1);
        mcu_sel[0] = 1'b0;
        settle();
        mcu_sel[0] = 1'b1;
        wait_int1n(1'b0);
        mcu_sel[0] = 1'b0;
        settle();
        // Clear and a fresh edge in the same cycle
        mcu_sel[0] = 1'b1;
        p2_out     = strobe_low(P2_IRQ_CLR);
        settle();
        check_bit("int1n after clear with edge", int1n, 1'b1);
        p2_out = 8'hff;
        settle();
        check_bit("int1n after edge consumed", int1n, 1'b1);
        end_test();

        begin_test("bank flags and status pages");
        for (i = 0; i < 8; i++) begin
            p1_out  = port_byte_t'($urandom);
            p3_out  = port_byte_t'($urandom);
            p0_out  = port_byte_t'($urandom);
            p2_out  = port_byte_t'($urandom);
            mcu_sel = mcu_sel_t'($urandom);
            for (pg = 0; pg < 4; pg++) begin
                st_addr      = st_addr_t'($urandom);
                st_addr[7:6] = pg[1:0];
                settle();
            end
        end
        end_test();

        end_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== verilog/cop_cen_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock-enable generator
// One phase counter on the 24 MHz
// clock, decoded into the MCU,
// OPL and OPN enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_cen_gen (
    input  wire logic clk,
    input  wire logic rst24,
    output logic      cen_mcu,
    output logic      cen_opl,
    output logic      cen_opn
);

    import cop_pkg::*;

    localparam cen_cnt_t CNT_LAST = cen_cnt_t'(CEN_MODULUS - 1);

    cen_cnt_t cnt;

    // Shared phase, 0 to 47
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Each enable fires on the last phase of its divider.
    // 48 is a multiple of all three, so the pattern stays even across the wrap
    always_comb begin
        cen_mcu = (cnt % cen_cnt_t'(MCU_DIV)) == cen_cnt_t'(MCU_DIV - 1);
        cen_opl = (cnt % cen_cnt_t'(OPL_DIV)) == cen_cnt_t'(OPL_DIV - 1);
        cen_opn = (cnt % cen_cnt_t'(OPN_DIV)) == cen_cnt_t'(OPN_DIV - 1);
    end

    // Phase must never escape the modulus
    a_cnt_range : assert property (
        @(posedge clk) disable iff (rst24)
        cnt < cen_cnt_t'(CEN_MODULUS)
    ) else $error("cen counter out of range: %0d", cnt);

endmodule

`default_nettype wire

// ==== verilog/cop_mcu_bridge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main CPU to 8751 MCU bridge
// Clock enables, port-0 mailbox,
// MCU interrupt and status dump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_mcu_bridge (
    input  wire logic               clk,
    input  wire logic               rst24,
    // Main CPU side
    input  wire cop_pkg::host_word_t host_din,
    input  wire cop_pkg::mcu_sel_t   mcu_sel,
    // MCU port outputs
    input  wire cop_pkg::port_byte_t p0_out,
    input  wire cop_pkg::port_byte_t p1_out,
    input  wire cop_pkg::port_byte_t p2_out,
    input  wire cop_pkg::port_byte_t p3_out,
    input  wire cop_pkg::st_addr_t   st_addr,
    // Clock enables
    output logic                    cen_mcu,
    output logic                    cen_opl,
    output logic                    cen_opn,
    // MCU port inputs
    output cop_pkg::port_byte_t      p0_in,
    output cop_pkg::port_byte_t      p3_in,
    output logic                    int1n,
    output cop_pkg::host_word_t      host_dout,
    // Status and ROM banks
    output cop_pkg::port_byte_t      st_dout,
    output logic [1:0]              snd_flag,
    output logic [1:0]              b1_flag,
    output logic                    b0_flag,
    output logic [1:0]              mix_flag,
    output logic [2:0]              crback
);

    cop_cen_gen u_cen (
        .clk     (clk),
        .rst24   (rst24),
        .cen_mcu (cen_mcu),
        .cen_opl (cen_opl),
        .cen_opn (cen_opn)
    );

    cop_mcu_mailbox u_mailbox (
        .clk       (clk),
        .rst24     (rst24),
        .host_din  (host_din),
        .mcu_sel   (mcu_sel),
        .p0_out    (p0_out),
        .p2_out    (p2_out),
        .p3_out    (p3_out),
        .p0_in     (p0_in),
        .p3_in     (p3_in),
        .host_dout (host_dout)
    );

    // Select bit 0 is the interrupt request line
    cop_mcu_irq u_irq (
        .clk     (clk),
        .rst24   (rst24),
        .sel_req (mcu_sel[0]),
        .p2_out  (p2_out),
        .int1n   (int1n)
    );

    cop_status_dump u_status (
        .clk       (clk),
        .rst24     (rst24),
        .st_addr   (st_addr),
        .host_dout (host_dout),
        .p1_out    (p1_out),
        .p3_out    (p3_out),
        .int1n     (int1n),
        .st_dout   (st_dout),
        .snd_flag  (snd_flag),
        .b1_flag   (b1_flag),
        .b0_flag   (b0_flag),
        .mix_flag  (mix_flag),
        .crback    (crback)
    );

endmodule

`default_nettype wire

// ==== verilog/cop_mcu_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU interrupt request
// Set on a rising select edge,
// cleared from MCU port 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_mcu_irq (
    input  wire logic               clk,
    input  wire logic               rst24,
    input  wire logic               sel_req,
    input  wire cop_pkg::port_byte_t p2_out,
    output logic                    int1n
);

    import cop_pkg::*;

    logic sel_req_l;
    logic sel_rise;
    logic irq_clr;

    assign sel_rise = sel_req & ~sel_req_l;

    // Clear line is active low
    assign irq_clr = ~p2_out[P2_IRQ_CLR];

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            sel_req_l <= 1'b0;
            int1n     <= 1'b1;
        end else begin
            sel_req_l <= sel_req;
            // Clear before set
            if (irq_clr) begin
                int1n <= 1'b1;
            end else if (sel_rise) begin
                int1n <= 1'b0;
            end
        end
    end

    a_clr_releases : assert property (
        @(posedge clk) disable iff (rst24)
        irq_clr |=> int1n
    ) else $error("int1n still low after MCU clear");

endmodule

`default_nettype wire

// ==== verilog/cop_mcu_mailbox.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU port-0 mailbox
// Byte latches between the main
// CPU word and MCU port 0, steered
// by port-2 strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_mcu_mailbox (
    input  wire logic               clk,
    input  wire logic               rst24,
    input  wire cop_pkg::host_word_t host_din,
    input  wire cop_pkg::mcu_sel_t   mcu_sel,
    input  wire cop_pkg::port_byte_t p0_out,
    input  wire cop_pkg::port_byte_t p2_out,
    input  wire cop_pkg::port_byte_t p3_out,
    output cop_pkg::port_byte_t      p0_in,
    output cop_pkg::port_byte_t      p3_in,
    output cop_pkg::host_word_t      host_dout
);

    import cop_pkg::*;

    logic rd_hi;
    logic rd_lo;
    logic wr_hi;
    logic wr_lo;

    // Port 2 strobes are active low
    assign rd_hi = ~p2_out[P2_RD_HI];
    assign rd_lo = ~p2_out[P2_RD_LO];
    assign wr_hi = ~p2_out[P2_WR_HI];
    assign wr_lo = ~p2_out[P2_WR_LO];

    // Select lines 5:3 show up on the top of port 3
    assign p3_in = {mcu_sel[5:3], p3_out[4:0]};

    // MCU reads of the host word, one byte at a time
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            p0_in <= '0;
        end else begin
            if (rd_hi) begin
                p0_in <= host_din[15:8];
            end
            // Low byte wins when both strobes are down
            if (rd_lo) begin
                p0_in <= host_din[7:0];
            end
        end
    end

    // MCU writes back toward the host
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            host_dout <= '0;
        end else begin
            if (wr_hi) begin
                host_dout[15:8] <= p0_out;
            end
            if (wr_lo) begin
                host_dout[7:0] <= p0_out;
            end
        end
    end

    // A write strobe lands the port-0 byte in its half on the next cycle
    a_wr_hi_lands : assert property (
        @(posedge clk) disable iff (rst24)
        wr_hi |=> host_dout[15:8] == $past(p0_out)
    ) else $error("high write byte not latched");

    a_wr_lo_lands : assert property (
        @(posedge clk) disable iff (rst24)
        wr_lo |=> host_dout[7:0] == $past(p0_out)
    ) else $error("low write byte not latched");

endmodule

`default_nettype wire

// ==== verilog/cop_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU bridge shared definitions
// Widths, port bit positions,
// status page codes and the
// clock-enable divider constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package cop_pkg;

    // One 8751 port or latch byte
    typedef logic [7:0]  port_byte_t;

    // Main CPU data word
    typedef logic [15:0] host_word_t;

    // Main CPU select lines into the MCU
    typedef logic [5:0]  mcu_sel_t;

    // Status dump address, page code in the top two bits
    typedef logic [7:0]  st_addr_t;

    // Phase counter for the clock enables
    typedef logic [5:0]  cen_cnt_t;

    // Counter wraps at the LCM of the three dividers
    localparam int unsigned CEN_MODULUS = 48;

    // 24 MHz divided down
    localparam int unsigned MCU_DIV = 3;   // 8 MHz
    localparam int unsigned OPL_DIV = 8;   // 3 MHz
    localparam int unsigned OPN_DIV = 16;  // 1.5 MHz

    // Port 2 bit that clears the MCU interrupt, active low
    localparam int unsigned P2_IRQ_CLR = 3;

    // Port 2 mailbox strobes, all active low
    localparam int unsigned P2_RD_HI = 4;
    localparam int unsigned P2_RD_LO = 5;
    localparam int unsigned P2_WR_LO = 6;
    localparam int unsigned P2_WR_HI = 7;

    // Status page codes in st_addr[7:6]
    localparam logic [1:0] ST_PAGE_LO   = 2'd0;
    localparam logic [1:0] ST_PAGE_HI   = 2'd1;
    localparam logic [1:0] ST_PAGE_BANK = 2'd2;
    localparam logic [1:0] ST_PAGE_CTRL = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/cop_status_dump.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank flags and status dump
// Splits ports 1 and 3 into the
// ROM bank controls and registers
// the selected status page
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cop_status_dump (
    input  wire logic               clk,
    input  wire logic               rst24,
    input  wire cop_pkg::st_addr_t   st_addr,
    input  wire cop_pkg::host_word_t host_dout,
    input  wire cop_pkg::port_byte_t p1_out,
    input  wire cop_pkg::port_byte_t p3_out,
    input  wire logic               int1n,
    output cop_pkg::port_byte_t      st_dout,
    output logic [1:0]              snd_flag,
    output logic [1:0]              b1_flag,
    output logic                    b0_flag,
    output logic [1:0]              mix_flag,
    output logic [2:0]              crback
);

    import cop_pkg::*;

    logic [1:0] page;
    port_byte_t bank_byte;
    port_byte_t ctrl_byte;

    // ROM bank controls straight off the MCU ports
    assign snd_flag = p1_out[6:5];
    assign b1_flag  = p1_out[4:3];
    assign b0_flag  = p1_out[2];
    assign mix_flag = p1_out[1:0];
    assign crback   = p3_out[2:0];

    assign page = st_addr[7:6];

    // Bit 7 of port 1 is not a bank control
    assign bank_byte = {1'b0, p1_out[6:0]};

    // Interrupt state on top, bank select at the bottom
    assign ctrl_byte = {int1n, 4'b0000, crback};

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            st_dout <= '0;
        end else begin
            case (page)
                ST_PAGE_LO:   st_dout <= host_dout[7:0];
                ST_PAGE_HI:   st_dout <= host_dout[15:8];
                ST_PAGE_BANK: st_dout <= bank_byte;
                ST_PAGE_CTRL: st_dout <= ctrl_byte;
                default:      st_dout <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire
